// File: list.f
+incdir+.
fp8_pkg.sv
fp8_operand_stage.sv
fp8_div_core.sv
fp8_sqrt_core.sv
fp8_result_stage.sv
fp8_divsqrt.sv
tb_fp8_divsqrt.sv

// File: run.sh
#!/bin/sh
# Build and run the FP8 divide/sqrt testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -j 0 --top-module tb_fp8_divsqrt -f list.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_fp8_divsqrt 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q 'All tests passed!'; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: tb_fp8_model.svh
/*
 * Reference model for the FP8 divide and square-root testbench.
 * Operands become real numbers, the exact result is computed in real
 * arithmetic and the nearest code of the format is found by a full scan.
 * Included inside the testbench module, which imports fp8_pkg.
 */
`ifndef TB_FP8_MODEL_SVH
`define TB_FP8_MODEL_SVH

function automatic int man_bits(input fp_format_e fmt);
  return (fmt == FP8) ? FP8_MAN_BITS : FP8ALT_MAN_BITS;
endfunction

function automatic int exp_bias(input fp_format_e fmt);
  return (fmt == FP8) ? FP8_BIAS : FP8ALT_BIAS;
endfunction

// Biased exponent with all bits set
function automatic int exp_top(input fp_format_e fmt);
  return (1 << (7 - man_bits(fmt))) - 1;
endfunction

function automatic real pow2(input int n);
  real r;
  int  i;
  r = 1.0;
  if (n >= 0) begin
    for (i = 0; i < n; i++) begin
      r = r * 2.0;
    end
  end else begin
    for (i = 0; i < -n; i++) begin
      r = r / 2.0;
    end
  end
  return r;
endfunction

// Magnitude of a code, subnormals count as zero
function automatic real code_value(input logic [6:0] mag, input fp_format_e fmt);
  int p;
  int e;
  int m;
  p = man_bits(fmt);
  e = int'(mag) >> p;
  m = int'(mag) & ((1 << p) - 1);
  if (e == 0) begin
    return 0.0;
  end
  return (1.0 + real'(m) / real'(1 << p)) * pow2(e - exp_bias(fmt));
endfunction

function automatic fp_class_e classify(input logic [7:0] v, input fp_format_e fmt);
  int p;
  int e;
  int m;
  p = man_bits(fmt);
  e = int'(v[6:0]) >> p;
  m = int'(v[6:0]) & ((1 << p) - 1);
  if (e == 0) begin
    return ZERO;
  end
  if (e != exp_top(fmt)) begin
    return NORMAL;
  end
  if (m == 0) begin
    return INF;
  end
  // Fraction MSB set means quiet
  return (((m >> (p - 1)) & 1) == 1) ? QNAN : SNAN;
endfunction

// Round a positive real magnitude to nearest even, then range check
function automatic logic [12:0] round_real(input real x, input logic sign,
                                           input fp_format_e fmt);
  int      p;
  int      bias;
  int      top;
  int      code;
  int      best;
  real     v;
  real     d;
  real     best_d;
  real     max_fin;
  real     min_norm;
  status_t st;
  p        = man_bits(fmt);
  bias     = exp_bias(fmt);
  top      = exp_top(fmt);
  st       = '0;
  max_fin  = code_value(7'(((top - 1) << p) | ((1 << p) - 1)), fmt);
  min_norm = pow2(1 - bias);
  // Half an ulp past the largest finite value ties away to inf (odd LSB)
  if (x >= max_fin + pow2(top - 1 - bias - p - 1)) begin
    st.of = 1'b1;
    st.nx = 1'b1;
    return {sign, 7'(top << p), st};
  end
  // Rounding comes first, values that round up to the minimum normal survive
  if (x < min_norm * (1.0 - pow2(-(p + 2)))) begin
    st.uf = 1'b1;
    st.nx = 1'b1;
    return {sign, 7'b0, st};
  end
  best   = 1 << p;
  best_d = -1.0;
  for (code = 1 << p; code < (top << p); code++) begin
    v = code_value(7'(code), fmt);
    d = (v > x) ? v - x : x - v;
    // Adjacent codes, so on a tie the later even one wins
    if (best_d < 0.0 || d < best_d || (d == best_d && code[0] == 1'b0)) begin
      best   = code;
      best_d = d;
    end
  end
  st.nx = (best_d != 0.0);
  return {sign, 7'(best), st};
endfunction

// Expected {value, status} for one operation
function automatic logic [12:0] expected_result(input operation_e op, input fp_format_e fmt,
                                                input logic [7:0] a, input logic [7:0] b);
  fp_class_e  ca;
  fp_class_e  cb;
  logic       s;
  logic [7:0] nan_code;
  logic [7:0] inf_code;
  status_t    st;
  ca       = classify(a, fmt);
  cb       = classify(b, fmt);
  st       = '0;
  nan_code = 8'((exp_top(fmt) << man_bits(fmt)) | (1 << (man_bits(fmt) - 1)));
  inf_code = 8'(exp_top(fmt) << man_bits(fmt));
  if (op == DIV) begin
    s = a[7] ^ b[7];
    if (ca == QNAN || ca == SNAN || cb == QNAN || cb == SNAN) begin
      st.nv = (ca == SNAN) || (cb == SNAN);
      return {nan_code, st};
    end
    if ((ca == ZERO && cb == ZERO) || (ca == INF && cb == INF)) begin
      st.nv = 1'b1;
      return {nan_code, st};
    end
    // Infinite dividend gives inf without DZ, even over zero
    if (ca == INF) begin
      return {inf_code | {s, 7'b0}, st};
    end
    // Only a finite nonzero dividend over zero flags DZ
    if (cb == ZERO) begin
      st.dz = 1'b1;
      return {inf_code | {s, 7'b0}, st};
    end
    if (ca == ZERO || cb == INF) begin
      return {s, 7'b0, st};
    end
    return round_real(code_value(a[6:0], fmt) / code_value(b[6:0], fmt), s, fmt);
  end
  // Square root of operand 0
  if (ca == QNAN || ca == SNAN) begin
    st.nv = (ca == SNAN);
    return {nan_code, st};
  end
  if (a[7] && (ca == NORMAL || ca == INF)) begin
    st.nv = 1'b1;
    return {nan_code, st};
  end
  if (ca == ZERO) begin
    return {a[7], 7'b0, st};
  end
  if (ca == INF) begin
    return {inf_code, st};
  end
  return round_real($sqrt(code_value(a[6:0], fmt)), 1'b0, fmt);
endfunction

`endif

// File: tb_fp8_divsqrt.sv
/*
 * Testbench for the FP8 divide and square-root unit.
 * Random and directed operations go in on the falling edge, every accepted
 * request queues its model result, outputs are scored in order.
 * Covers latency, special values, back-pressure, flush and busy.
 */
`timescale 1ns/1ps

module tb_fp8_divsqrt import fp8_pkg::*; ();

  logic            clk;
  logic            rst_n;
  logic            flush;
  logic            in_valid;
  logic            in_ready;
  operation_e      op;
  fp_format_e      fmt;
  logic [1:0][7:0] operands;
  logic [7:0]      result;
  status_t         status;
  logic            out_valid;
  logic            out_ready;
  logic            busy;

  integer      seed;
  int          cycle;
  int          accepted;
  int          out_count;
  string       phase;
  logic [12:0] exp_q [$];
  int          acc_q [$];
  logic        in_hold;
  logic        was_stalled;
  logic [12:0] held;

  `include "tb_fp8_model.svh"

  fp8_divsqrt u_dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .flush_i     (flush),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .op_i        (op),
    .fmt_i       (fmt),
    .operands_i  (operands),
    .result_o    (result),
    .status_o    (status),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .busy_o      (busy)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // --------------------------------------------------
  // Reporting
  // --------------------------------------------------
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "Stopping at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      fail_run($sformatf("FAILED %s: expected %0h, actual %0h", name, expected, actual));
    end
  endtask

  function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // --------------------------------------------------
  // Cycle stepping and scoreboard
  // --------------------------------------------------
  // Inputs are already driven, score the handshakes of the coming edge
  task automatic settle_and_score(input logic check_latency);
    int lat;
    #1;
    if (was_stalled) begin
      check_value({phase, " held valid"}, 32'd1, 32'(out_valid));
      check_value({phase, " held result"}, 32'(held), 32'({result, status}));
    end
    was_stalled = out_valid && !out_ready && !flush;
    held        = {result, status};
    if (out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        fail_run("Output handshake with no request outstanding");
      end else begin
        out_count++;
        check_value($sformatf("%s out %0d", phase, out_count),
                    32'(exp_q.pop_front()), 32'({result, status}));
        lat = acc_q.pop_front();
        if (check_latency) begin
          check_value({phase, " latency"}, NUM_INP_REGS + NUM_OUT_REGS, cycle - lat);
        end
      end
    end
    if (in_valid && in_ready) begin
      exp_q.push_back(expected_result(op, fmt, operands[0], operands[1]));
      acc_q.push_back(cycle);
      accepted++;
    end
    in_hold = in_valid && !in_ready;
    @(posedge clk);
    cycle++;
    @(negedge clk);
  endtask

  // New random request, unless the last one is still waiting
  task automatic pick_request();
    if (!in_hold) begin
      op          = operation_e'(rand_below(2));
      fmt         = fp_format_e'(rand_below(2));
      operands[0] = 8'(rand_below(256));
      operands[1] = 8'(rand_below(256));
      // Mostly positive radicands
      if (op == SQRT && rand_below(4) != 0) begin
        operands[0][7] = 1'b0;
      end
      in_valid = (rand_below(4) != 0);
    end
  endtask

  task automatic random_run(input string name, input int count, input int ready_pct,
                            input logic check_latency);
    int target;
    int guard;
    phase  = name;
    target = accepted + count;
    guard  = 0;
    while (accepted < target) begin
      guard++;
      if (guard > count * 20) begin
        fail_run($sformatf("Timeout in %s, requests are not accepted", name));
      end
      pick_request();
      out_ready = (rand_below(100) < ready_pct);
      settle_and_score(check_latency);
    end
  endtask

  task automatic drain(input string name);
    int guard;
    phase     = name;
    in_valid  = 1'b0;
    out_ready = 1'b1;
    guard     = 0;
    while (exp_q.size() != 0) begin
      guard++;
      if (guard > 50) begin
        fail_run($sformatf("Timeout in %s, results did not come out", name));
      end
      settle_and_score(1'b0);
    end
    check_value({name, " out_valid"}, 32'd0, 32'(out_valid));
    check_value({name, " busy"}, 32'd0, 32'(busy));
  endtask

  // Hand-derived expectation checked against the model, then sent through the DUT
  task automatic send_directed(input operation_e o, input fp_format_e f, input logic [7:0] a,
                               input logic [7:0] b, input logic [12:0] want);
    int target;
    int guard;
    phase = "directed";
    check_value($sformatf("directed model %0h %0h", a, b), 32'(want),
                32'(expected_result(o, f, a, b)));
    op          = o;
    fmt         = f;
    operands[0] = a;
    operands[1] = b;
    in_valid    = 1'b1;
    out_ready   = 1'b1;
    target      = accepted + 1;
    guard       = 0;
    while (accepted < target) begin
      guard++;
      if (guard > 20) begin
        fail_run("Timeout, directed request was not accepted");
      end
      settle_and_score(1'b1);
    end
    in_valid = 1'b0;
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin : main
    int i;
    seed        = 32'h3eec;
    rst_n       = 1'b0;
    flush       = 1'b0;
    in_valid    = 1'b0;
    op          = DIV;
    fmt         = FP8;
    operands    = '0;
    out_ready   = 1'b0;
    cycle       = 0;
    accepted    = 0;
    out_count   = 0;
    in_hold     = 1'b0;
    was_stalled = 1'b0;
    held        = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("reset in_ready", 32'd1, 32'(in_ready));
    check_value("reset out_valid", 32'd0, 32'(out_valid));
    check_value("reset busy", 32'd0, 32'(busy));

    random_run("random", 300, 100, 1'b1);
    drain("random drain");

    // Status order is nv dz of uf nx
    send_directed(DIV, FP8, 8'h00, 8'h00, {8'h7E, 5'b10000});
    send_directed(DIV, FP8, 8'h3C, 8'h80, {8'hFC, 5'b01000});
    send_directed(DIV, FP8, 8'h7C, 8'h00, {8'h7C, 5'b00000});
    send_directed(DIV, FP8, 8'h7C, 8'hFC, {8'h7E, 5'b10000});
    send_directed(SQRT, FP8, 8'hBC, 8'h00, {8'h7E, 5'b10000});
    send_directed(DIV, FP8, 8'h7D, 8'h3C, {8'h7E, 5'b10000});
    send_directed(DIV, FP8, 8'h7E, 8'h3C, {8'h7E, 5'b00000});
    send_directed(SQRT, FP8, 8'h80, 8'h00, {8'h80, 5'b00000});
    send_directed(SQRT, FP8, 8'h00, 8'h00, {8'h00, 5'b00000});
    send_directed(SQRT, FP8, 8'h7C, 8'h00, {8'h7C, 5'b00000});
    send_directed(DIV, FP8ALT, 8'h00, 8'h00, {8'h7C, 5'b10000});
    send_directed(DIV, FP8ALT, 8'hB8, 8'h00, {8'hF8, 5'b01000});
    send_directed(SQRT, FP8ALT, 8'h79, 8'h00, {8'h7C, 5'b10000});
    send_directed(SQRT, FP8ALT, 8'h7C, 8'h00, {8'h7C, 5'b00000});
    send_directed(SQRT, FP8ALT, 8'h78, 8'h00, {8'h78, 5'b00000});
    send_directed(DIV, FP8ALT, 8'h38, 8'h78, {8'h00, 5'b00000});
    send_directed(SQRT, FP8ALT, 8'h48, 8'h00, {8'h40, 5'b00000});
    drain("directed drain");

    random_run("backpressure", 300, 60, 1'b0);
    drain("backpressure drain");

    // Fill the pipeline with the output stalled, then flush it
    phase     = "flush fill";
    out_ready = 1'b0;
    for (i = 0; i < 3; i++) begin
      pick_request();
      in_valid = 1'b1;
      settle_and_score(1'b0);
    end
    check_value("flush busy before", 32'd1, 32'(busy));
    flush    = 1'b1;
    in_valid = 1'b0;
    in_hold  = 1'b0;
    settle_and_score(1'b0);
    flush = 1'b0;
    exp_q.delete();
    acc_q.delete();
    check_value("flush out_valid after", 32'd0, 32'(out_valid));
    check_value("flush busy after", 32'd0, 32'(busy));

    random_run("after flush", 40, 70, 1'b0);
    drain("final drain");

    $display("All tests passed!");
    $finish;
  end

endmodule

// File: fp8_divsqrt.sv
/*
 * Top level of the FP8 divide and square-root unit.
 * Accepts one operation per valid/ready transfer and returns the rounded
 * result with IEEE status NUM_INP_REGS+NUM_OUT_REGS edges later, in order.
 * flush_i drops every item in flight, busy_o flags any work in the unit.
 */
`timescale 1ns/1ps

module fp8_divsqrt import fp8_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            flush_i,
  input  logic            in_valid_i,
  output logic            in_ready_o,
  input  operation_e      op_i,
  input  fp_format_e      fmt_i,
  input  logic [1:0][7:0] operands_i,
  output logic [7:0]      result_o,
  output status_t         status_o,
  output logic            out_valid_o,
  input  logic            out_ready_i,
  output logic            busy_o
);

  op_req_t  req;
  op_req_t  div_req;
  op_req_t  sqrt_req;
  logic     req_valid;
  logic     req_ready;
  logic     inp_busy;
  logic     out_busy;
  logic     op_start;
  fp8_raw_t div_raw;
  fp8_raw_t sqrt_raw;
  fp8_raw_t raw_sel;
  result_t  result;

  // --------------------------------------------------
  // Operand decode and input pipeline
  // --------------------------------------------------
  fp8_operand_stage u_operand_stage (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .op_i        (op_i),
    .fmt_i       (fmt_i),
    .operands_i  (operands_i),
    .req_o       (req),
    .req_valid_o (req_valid),
    .req_ready_i (req_ready),
    .busy_o      (inp_busy)
  );

  // An item reaching the cores during a flush is dropped
  assign op_start = req_valid & ~flush_i;

  // --------------------------------------------------
  // Core select
  // --------------------------------------------------
  // Idle core sees zeros, so it does not toggle
  always_comb begin : silence_unused_core
    div_req  = '0;
    sqrt_req = '0;
    if (op_start) begin
      if (req.op == DIV) begin
        div_req = req;
      end else begin
        sqrt_req = req;
      end
    end
  end

  fp8_div_core u_div_core (
    .req_i (div_req),
    .raw_o (div_raw)
  );

  fp8_sqrt_core u_sqrt_core (
    .req_i (sqrt_req),
    .raw_o (sqrt_raw)
  );

  assign raw_sel = (req.op == DIV) ? div_raw : sqrt_raw;

  // --------------------------------------------------
  // Rounding and output pipeline
  // --------------------------------------------------
  fp8_result_stage u_result_stage (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .raw_i       (raw_sel),
    .raw_valid_i (op_start),
    .raw_ready_o (req_ready),
    .result_o    (result),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .busy_o      (out_busy)
  );

  assign result_o = result.value;
  assign status_o = result.status;
  assign busy_o   = inp_busy | out_busy | op_start;

  // Empty pipeline must accept at once after reset
  assert property (@(posedge clk_i) $rose(rst_n_i) |-> in_ready_o);

endmodule

// File: fp8_result_stage.sv
/*
 * Result stage of the FP8 unit.
 * Rounds the raw core result to nearest even at the format's precision,
 * checks overflow and underflow, packs the byte, then carries it through
 * NUM_OUT_REGS elastic register stages to the output.
 */
`timescale 1ns/1ps

module fp8_result_stage import fp8_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     flush_i,
  input  fp8_raw_t raw_i,
  input  logic     raw_valid_i,
  output logic     raw_ready_o,
  output result_t  result_o,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output logic     busy_o
);

  logic              g;
  logic              s;
  logic              round_up;
  logic              carry;
  logic [4:0]        sum;
  logic [2:0]        frac;
  logic signed [7:0] bias;
  logic signed [7:0] exp_max;
  logic signed [7:0] biased;
  result_t           res_d;

  // --------------------------------------------------
  // Round, rebias and pack
  // --------------------------------------------------
  always_comb begin : round_pack
    if (raw_i.fmt == FP8) begin
      // Only three mantissa bits survive, the fourth becomes guard
      g        = raw_i.man[0];
      s        = raw_i.guard | raw_i.sticky;
      round_up = g & (s | raw_i.man[1]);
      sum      = 5'(raw_i.man[3:1]) + 5'(round_up);
      carry    = sum[3];
      frac     = {1'b0, sum[1:0]};
      bias     = 8'(FP8_BIAS);
      exp_max  = 8'(FP8_EXP_MAX);
    end else begin
      g        = raw_i.guard;
      s        = raw_i.sticky;
      round_up = g & (s | raw_i.man[0]);
      sum      = 5'(raw_i.man) + 5'(round_up);
      carry    = sum[4];
      frac     = sum[2:0];
      bias     = 8'(FP8ALT_BIAS);
      exp_max  = 8'(FP8ALT_EXP_MAX);
    end
    // Mantissa carry leaves a zero fraction and bumps the exponent
    biased = 8'(raw_i.exp) + 8'(carry) + bias;

    res_d           = '0;
    res_d.status    = raw_i.status;
    res_d.status.nx = g | s;
    if (raw_i.special) begin
      res_d.value  = raw_i.special_val;
      res_d.status = raw_i.status;
    end else if (biased >= exp_max) begin
      res_d.value     = ((raw_i.fmt == FP8) ? INF_FP8 : INF_FP8ALT) | {raw_i.sign, 7'b0};
      res_d.status.of = 1'b1;
      res_d.status.nx = 1'b1;
    end else if (biased <= 8'sd0) begin
      // No subnormals, flush to signed zero
      res_d.value     = {raw_i.sign, 7'b0};
      res_d.status.uf = 1'b1;
      res_d.status.nx = 1'b1;
    end else if (raw_i.fmt == FP8) begin
      res_d.value = {raw_i.sign, biased[4:0], frac[FP8_MAN_BITS-1:0]};
    end else begin
      res_d.value = {raw_i.sign, biased[3:0], frac[FP8ALT_MAN_BITS-1:0]};
    end
  end

  // --------------------------------------------------
  // Elastic output pipeline
  // --------------------------------------------------
  result_t res_q   [NUM_OUT_REGS+1];
  logic    valid_q [NUM_OUT_REGS+1];
  logic    ready   [NUM_OUT_REGS+1];

  assign res_q[0]            = res_d;
  assign valid_q[0]          = raw_valid_i;
  assign ready[NUM_OUT_REGS] = out_ready_i;
  assign raw_ready_o         = ready[0];

  for (genvar i = 0; i < NUM_OUT_REGS; i++) begin : gen_out_regs
    assign ready[i] = ready[i+1] | ~valid_q[i+1];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (flush_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (ready[i] && valid_q[i]) begin
        res_q[i+1] <= res_q[i];
      end
    end
  end

  assign result_o    = res_q[NUM_OUT_REGS];
  assign out_valid_o = valid_q[NUM_OUT_REGS];

  always_comb begin : busy_or
    busy_o = 1'b0;
    for (int unsigned i = 1; i <= NUM_OUT_REGS; i++) begin
      busy_o = busy_o | valid_q[i];
    end
  end

  // Flush kills everything in flight on both sides
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |=> !out_valid_o);

endmodule

// File: fp8_sqrt_core.sv
/*
 * Combinational square-root core of the FP8 unit.
 * Works on operand 0 only. A restoring integer root gives four mantissa
 * bits plus guard, sticky comes from the final remainder.
 */
`timescale 1ns/1ps

module fp8_sqrt_core import fp8_pkg::*; (
  input  op_req_t  req_i,
  output fp8_raw_t raw_o
);

  fp8_unpacked_t a;
  logic          any_nan;
  logic          invalid;
  logic [7:0]    nan_pat;
  logic [7:0]    inf_pat;
  logic [4:0]    man_adj;
  logic [9:0]    radicand;
  logic [4:0]    root;
  logic [6:0]    rem;

  assign a = req_i.opd[0];

  // --------------------------------------------------
  // Class checks and special patterns
  // --------------------------------------------------
  assign any_nan = a.cls inside {QNAN, SNAN};
  // Negative nonzero operand has no real root
  assign invalid = (a.cls == SNAN) || (a.sign && (a.cls inside {NORMAL, INF}));
  assign nan_pat = (req_i.fmt == FP8) ? CANON_NAN_FP8 : CANON_NAN_FP8ALT;
  assign inf_pat = (req_i.fmt == FP8) ? INF_FP8 : INF_FP8ALT;

  // --------------------------------------------------
  // Integer root
  // --------------------------------------------------
  // Odd exponent moves one factor of two into the mantissa
  assign man_adj  = a.exp[0] ? {a.man, 1'b0} : {1'b0, a.man};
  // Scaled so that the root lands in [16, 32)
  assign radicand = {man_adj, 5'b0};

  always_comb begin : restoring_root
    logic [8:0] acc;
    logic [8:0] trial;
    acc  = '0;
    root = '0;
    for (int i = 4; i >= 0; i--) begin
      // Bring down the next bit pair
      acc   = {acc[6:0], radicand[2*i+1 -: 2]};
      trial = {2'b0, root, 2'b01};
      if (acc >= trial) begin
        acc  = acc - trial;
        root = {root[3:0], 1'b1};
      end else begin
        root = {root[3:0], 1'b0};
      end
    end
    rem = acc[6:0];
  end

  always_comb begin : sqrt_result
    raw_o        = '0;
    raw_o.fmt    = req_i.fmt;
    raw_o.sign   = 1'b0;
    // Arithmetic shift halves the even exponent, also below zero
    raw_o.exp    = 7'(a.exp >>> 1);
    raw_o.man    = root[4:1];
    raw_o.guard  = root[0];
    raw_o.sticky = (rem != '0);

    if (any_nan || invalid) begin
      raw_o.special     = 1'b1;
      raw_o.special_val = nan_pat;
      raw_o.status.nv   = invalid;
    end else if (a.cls == ZERO) begin
      // Signed zero comes back unchanged
      raw_o.special     = 1'b1;
      raw_o.special_val = {a.sign, 7'b0};
    end else if (a.cls == INF) begin
      raw_o.special     = 1'b1;
      raw_o.special_val = inf_pat;
    end
  end

endmodule

// File: fp8_div_core.sv
/*
 * Combinational divide core of the FP8 unit.
 * Operand 0 is the dividend, operand 1 the divisor. The result leaves
 * unrounded with guard and sticky, or as a finished special pattern.
 */
`timescale 1ns/1ps

module fp8_div_core import fp8_pkg::*; (
  input  op_req_t  req_i,
  output fp8_raw_t raw_o
);

  fp8_unpacked_t a;
  fp8_unpacked_t b;
  logic          sign;
  logic          any_nan;
  logic          invalid;
  logic [7:0]    nan_pat;
  logic [7:0]    inf_pat;
  logic [3:0]    divisor;
  logic [8:0]    dividend;
  logic [5:0]    quot;
  logic [3:0]    rem;

  assign a    = req_i.opd[0];
  assign b    = req_i.opd[1];
  assign sign = a.sign ^ b.sign;

  // --------------------------------------------------
  // Class checks and special patterns
  // --------------------------------------------------
  assign any_nan = (a.cls inside {QNAN, SNAN}) || (b.cls inside {QNAN, SNAN});
  // SNAN input, 0/0 and inf/inf raise NV
  assign invalid = (a.cls == SNAN) || (b.cls == SNAN) ||
                   (a.cls == ZERO && b.cls == ZERO) ||
                   (a.cls == INF && b.cls == INF);
  assign nan_pat = (req_i.fmt == FP8) ? CANON_NAN_FP8 : CANON_NAN_FP8ALT;
  assign inf_pat = ((req_i.fmt == FP8) ? INF_FP8 : INF_FP8ALT) | {sign, 7'b0};

  // --------------------------------------------------
  // Mantissa division
  // --------------------------------------------------
  // Divisor forced to 1.0 for non-normal classes, keeps the divide defined
  assign divisor  = (b.cls == NORMAL) ? b.man : 4'b1000;
  // Ratio lies in (0.5, 2), five extra bits give 4 mantissa bits plus two more
  assign dividend = {a.man, 5'b0};
  assign quot     = 6'(dividend / 9'(divisor));
  assign rem      = 4'(dividend % 9'(divisor));

  always_comb begin : divide
    raw_o      = '0;
    raw_o.fmt  = req_i.fmt;
    raw_o.sign = sign;
    if (quot[5]) begin
      // Ratio at or above one
      raw_o.exp    = 7'(a.exp) - 7'(b.exp);
      raw_o.man    = quot[5:2];
      raw_o.guard  = quot[1];
      raw_o.sticky = quot[0] | (rem != '0);
    end else begin
      // Ratio below one, shift left once
      raw_o.exp    = 7'(a.exp) - 7'(b.exp) - 7'sd1;
      raw_o.man    = quot[4:1];
      raw_o.guard  = quot[0];
      raw_o.sticky = (rem != '0);
    end

    // Special cases override the arithmetic path
    if (any_nan || invalid) begin
      raw_o.special     = 1'b1;
      raw_o.special_val = nan_pat;
      raw_o.status.nv   = invalid;
    end else if (a.cls == INF) begin
      // Infinite dividend stays infinite, also over zero, with no DZ
      raw_o.special     = 1'b1;
      raw_o.special_val = inf_pat;
    end else if (b.cls == ZERO) begin
      // Finite nonzero over zero
      raw_o.special     = 1'b1;
      raw_o.special_val = inf_pat;
      raw_o.status.dz   = 1'b1;
    end else if (a.cls == ZERO || b.cls == INF) begin
      raw_o.special     = 1'b1;
      raw_o.special_val = {sign, 7'b0};
    end
  end

endmodule

// File: fp8_operand_stage.sv
/*
 * Operand stage of the FP8 divide and square-root unit.
 * Both operands are decoded into sign, unbiased exponent, mantissa and class,
 * then carried through NUM_INP_REGS elastic register stages.
 * Ready runs combinationally back through all stages, flush clears the valids.
 */
`timescale 1ns/1ps

module fp8_operand_stage import fp8_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            flush_i,
  input  logic            in_valid_i,
  output logic            in_ready_o,
  input  operation_e      op_i,
  input  fp_format_e      fmt_i,
  input  logic [1:0][7:0] operands_i,
  output op_req_t         req_o,
  output logic            req_valid_o,
  input  logic            req_ready_i,
  output logic            busy_o
);

  // Split one operand by format and remove the bias
  function automatic fp8_unpacked_t decode(input logic [7:0] val, input fp_format_e fmt);
    fp8_unpacked_t res;
    logic [4:0]    e_field;
    logic [4:0]    e_max;
    logic [2:0]    m_field;
    logic [5:0]    bias;
    res.sign = val[7];
    if (fmt == FP8) begin
      e_field = val[6:2];
      // FP8 fraction padded to the FP8ALT width
      m_field = {val[1:0], 1'b0};
      e_max   = 5'(FP8_EXP_MAX);
      bias    = 6'(FP8_BIAS);
    end else begin
      e_field = {1'b0, val[6:3]};
      m_field = val[2:0];
      e_max   = 5'(FP8ALT_EXP_MAX);
      bias    = 6'(FP8ALT_BIAS);
    end
    res.exp = 6'(e_field) - bias;
    res.man = {1'b1, m_field};
    res.cls = NORMAL;
    if (e_field == '0) begin
      // Zero and subnormal alike
      res.cls = ZERO;
      res.exp = '0;
      res.man = '0;
    end else if (e_field == e_max) begin
      // Fraction MSB tells quiet from signalling NaN
      res.cls = (m_field == '0) ? INF : (m_field[2] ? QNAN : SNAN);
    end
    return res;
  endfunction

  op_req_t req_d;
  op_req_t req_q   [NUM_INP_REGS+1];
  logic    valid_q [NUM_INP_REGS+1];
  logic    ready   [NUM_INP_REGS+1];

  always_comb begin : decode_operands
    req_d.op     = op_i;
    req_d.fmt    = fmt_i;
    req_d.opd[0] = decode(operands_i[0], fmt_i);
    req_d.opd[1] = decode(operands_i[1], fmt_i);
  end

  // --------------------------------------------------
  // Elastic input pipeline
  // --------------------------------------------------
  // Index 0 is the decoded input, index i is after i registers
  assign req_q[0]             = req_d;
  assign valid_q[0]           = in_valid_i;
  assign ready[NUM_INP_REGS]  = req_ready_i;
  assign in_ready_o           = ready[0];

  for (genvar i = 0; i < NUM_INP_REGS; i++) begin : gen_inp_regs
    // Advance when downstream takes data or only holds a bubble
    assign ready[i] = ready[i+1] | ~valid_q[i+1];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (flush_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end

    // Payload only moves with a valid item
    always_ff @(posedge clk_i) begin
      if (ready[i] && valid_q[i]) begin
        req_q[i+1] <= req_q[i];
      end
    end
  end

  assign req_o       = req_q[NUM_INP_REGS];
  assign req_valid_o = valid_q[NUM_INP_REGS];

  always_comb begin : busy_or
    busy_o = 1'b0;
    for (int unsigned i = 1; i <= NUM_INP_REGS; i++) begin
      busy_o = busy_o | valid_q[i];
    end
  end

  // Stalled request must not change under the cores
  assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
    req_valid_o && !req_ready_i |=> $stable(req_o));

endmodule

// File: fp8_pkg.sv
/*
 * Shared types and constants of the FP8 divide and square-root unit.
 * Every module of the unit takes them with a wildcard import in its header.
 * FP8 is 1/5/2 with bias 15, FP8ALT is 1/4/3 with bias 7.
 * Pipeline depths on both sides of the cores are set here.
 */
package fp8_pkg;

  // --------------------------------------------------
  // Formats, operations and status
  // --------------------------------------------------
  typedef enum logic {
    FP8,
    FP8ALT
  } fp_format_e;

  // Anything that is not a divide runs as square root
  typedef enum logic {
    DIV,
    SQRT
  } operation_e;

  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  // Operand class after decode, subnormals fold into ZERO
  typedef enum logic [2:0] {
    ZERO,
    NORMAL,
    INF,
    QNAN,
    SNAN
  } fp_class_e;

  // --------------------------------------------------
  // Pipeline payloads
  // --------------------------------------------------
  typedef struct packed {
    logic              sign;
    logic signed [5:0] exp;
    // Hidden bit at the MSB, fraction left aligned
    logic        [3:0] man;
    fp_class_e         cls;
  } fp8_unpacked_t;

  typedef struct packed {
    operation_e          op;
    fp_format_e          fmt;
    fp8_unpacked_t [1:0] opd;
  } op_req_t;

  // Unrounded core result, or a finished special pattern
  typedef struct packed {
    logic              sign;
    logic signed [6:0] exp;
    logic        [3:0] man;
    logic              guard;
    logic              sticky;
    logic              special;
    logic        [7:0] special_val;
    status_t           status;
    fp_format_e        fmt;
  } fp8_raw_t;

  typedef struct packed {
    logic [7:0] value;
    status_t    status;
  } result_t;

  // --------------------------------------------------
  // Pipeline depths and format constants
  // --------------------------------------------------
  localparam int unsigned NUM_INP_REGS = 1;
  localparam int unsigned NUM_OUT_REGS = 1;

  localparam int FP8_BIAS        = 15;
  localparam int FP8ALT_BIAS     = 7;
  localparam int FP8_MAN_BITS    = 2;
  localparam int FP8ALT_MAN_BITS = 3;
  // Biased exponent reserved for inf and NaN
  localparam int FP8_EXP_MAX     = 31;
  localparam int FP8ALT_EXP_MAX  = 15;

  localparam logic [7:0] CANON_NAN_FP8    = 8'h7E;
  localparam logic [7:0] CANON_NAN_FP8ALT = 8'h7C;
  // Positive infinity, sign is ORed in by the user
  localparam logic [7:0] INF_FP8          = 8'h7C;
  localparam logic [7:0] INF_FP8ALT       = 8'h78;

endpackage
